// ==== verilog.f ====
verilog/egr_tc_pkg.sv
verilog/egr_tc_fifo.sv
verilog/egr_tc_rr_sm.sv
verilog/egr_tc_apb_regs.sv
verilog/egr_tc_sched.sv
test/egr_tc_sched_properties.sv
test/egr_tc_sched_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module egr_tc_sched_tb \
  -f verilog.f \
  -o egr_tc_sim

# Result is taken from the log
./obj_dir/egr_tc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  exit 1
fi
exit 0

// ==== test/egr_tc_sched_tb.sv ====
/* Random-stimulus testbench for the egress scheduler. A per-TC queue model
   and an arbiter model predict every egress word and every APB read */

`timescale 1ns/1ps

module egr_tc_sched_tb;

  import egr_tc_pkg::*;

  localparam int DATA_WIDTH  = 32;
  localparam int FIFO_DEPTH  = 8;
  localparam int RUN_CYCLES  = 4000;
  localparam int APB_OPS     = 60;
  localparam int CYCLE_LIMIT = RUN_CYCLES + 3 * APB_OPS + 400;  // Burst and drain margin
  localparam int M_IDLE  = 0;
  localparam int M_RAND  = 1;
  localparam int M_PAUSE = 2;
  localparam int M_BURST = 3;
  localparam int M_DRAIN = 4;

  logic clk = 1'b0;
  logic reset_n;
  logic in_valid;
  tc_idx_t in_tc;
  logic [DATA_WIDTH-1:0] in_data;
  tc_mask_t pfc_xoff;
  logic tx_ready;
  logic tx_valid;
  tc_idx_t tx_tc;
  logic [DATA_WIDTH-1:0] tx_data;
  logic psel;
  logic penable;
  logic pwrite;
  apb_addr_t paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  logic [31:0] rng_state = 32'h8f77_c255;
  int mode;
  int cycles;

  // Model state
  logic [DATA_WIDTH-1:0] mq [NUM_TC][$];
  int occ [NUM_TC];
  int drops [NUM_TC];
  tx_cnt_t exp_cnt [NUM_TC];
  tc_mask_t m_en;
  tc_mask_t m_pfc;
  tc_mask_t m_drop;
  int m_state;  // NUM_TC stands for IDLE
  logic p_valid;
  tc_idx_t p_tc;
  logic [DATA_WIDTH-1:0] p_data;

  egr_tc_sched #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Round robin: first eligible TC after st, TC 0 first from idle
  function automatic int rr_pick(int st, tc_mask_t elig);
    int start;
    int cand;
    start = (st == NUM_TC) ? NUM_TC - 1 : st;
    for (int i = 1; i <= NUM_TC; i++) begin
      cand = (start + i) % NUM_TC;
      if (elig[cand]) return cand;
    end
    return NUM_TC;
  endfunction

  function automatic logic drained();
    for (int t = 0; t < NUM_TC; t++) begin
      if (occ[t] != 0) return 1'b0;
    end
    return (m_state == NUM_TC) && !p_valid;
  endfunction

  task automatic stop_failed();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic apb_write(apb_addr_t addr, logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(apb_addr_t addr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);  // Model checks prdata at this edge
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_failed();
    end
  end

  // Traffic driver
  always @(posedge clk) begin
    logic [31:0] r;
    r = next_rand();
    case (mode)
      M_RAND: begin
        in_valid <= r[0];
        in_tc    <= r[3:1];
        in_data  <= next_rand();
        tx_ready <= (r[5:4] != 2'b00);
        if (r[13:8] == 6'd0) pfc_xoff <= r[23:16];  // Rare change
      end
      M_PAUSE, M_BURST: begin
        in_valid <= (mode == M_BURST);
        in_tc    <= 3'd3;
        in_data  <= next_rand();
        tx_ready <= (r[5:4] != 2'b00);
        pfc_xoff <= 8'h08;
      end
      M_DRAIN: begin
        in_valid <= 1'b0;
        tx_ready <= 1'b1;
        pfc_xoff <= '0;
      end
      default: begin
        in_valid <= 1'b0;
        tx_ready <= 1'b1;
      end
    endcase
  end

  // Reference model, sees pre-edge values
  always @(posedge clk) begin
    tc_mask_t req;
    tc_mask_t clr;
    tc_mask_t new_en;
    tc_mask_t new_pfc;
    apb_addr_t off;
    logic is_cnt;
    logic exp_err;
    logic full;
    logic xfer;
    logic [31:0] exp_rd;
    clr     = '0;
    new_en  = m_en;
    new_pfc = m_pfc;
    if (!reset_n) begin
      for (int t = 0; t < NUM_TC; t++) begin
        mq[t].delete();
        occ[t]     = 0;
        drops[t]   = 0;
        exp_cnt[t] = '0;
      end
      m_en    = '1;
      m_pfc   = '1;
      m_drop  = '0;
      m_state = NUM_TC;
      p_valid = 1'b0;
    end else begin
      // Counters read here do not yet include this cycle's transfer
      if (psel && penable) begin
        off     = paddr - REG_TX_CNT_BASE;
        is_cnt  = (off < 8'd32) && (off[1:0] == 2'b00);
        exp_err = !(is_cnt || paddr == REG_TC_ENABLE || paddr == REG_PFC_ENABLE ||
                    paddr == REG_DROP_STATUS) || (pwrite && is_cnt);
        assert (pready)
          else begin
            $display("FAIL pready: got %h expected %h", pready, 1'b1);
            stop_failed();
          end
        assert (pslverr == exp_err)
          else begin
            $display("FAIL pslverr: got %h expected %h", pslverr, exp_err);
            stop_failed();
          end
        if (!pwrite && !exp_err) begin
          if (is_cnt) exp_rd = 32'(exp_cnt[off[4:2]]);
          else if (paddr == REG_TC_ENABLE) exp_rd = 32'(m_en);
          else if (paddr == REG_PFC_ENABLE) exp_rd = 32'(m_pfc);
          else exp_rd = 32'(m_drop);
          assert (prdata == exp_rd)
            else begin
              $display("FAIL prdata: got %h expected %h at %h", prdata, exp_rd, paddr);
              stop_failed();
            end
        end
        if (pwrite && !exp_err) begin
          if (paddr == REG_TC_ENABLE) new_en = pwdata[7:0];
          if (paddr == REG_PFC_ENABLE) new_pfc = pwdata[7:0];
          if (paddr == REG_DROP_STATUS) clr = pwdata[7:0];
        end
      end

      assert (tx_valid == (m_state != NUM_TC))
        else begin
          $display("FAIL tx_valid: got %h expected %h", tx_valid, m_state != NUM_TC);
          stop_failed();
        end
      if (m_state != NUM_TC) begin
        assert (tx_tc == tc_idx_t'(m_state))
          else begin
            $display("FAIL tx_tc: got %h expected %h", tx_tc, m_state);
            stop_failed();
          end
      end
      xfer = (m_state != NUM_TC) && tx_ready;
      if (xfer) begin
        assert (mq[m_state].size() > 0)
          else begin
            $display("Transfer granted to TC %0d while its model queue is empty", m_state);
            stop_failed();
          end
        assert (tx_data == mq[m_state][0])
          else begin
            $display("FAIL tx_data: got %h expected %h", tx_data, mq[m_state][0]);
            stop_failed();
          end
        void'(mq[m_state].pop_front());
        exp_cnt[m_state] = exp_cnt[m_state] + 16'd1;
      end

      // Full is judged before this cycle's pop
      full = p_valid && (occ[p_tc] == FIFO_DEPTH);
      if (xfer) occ[m_state]--;
      m_drop = m_drop & ~clr;
      if (p_valid) begin
        if (full) begin
          drops[p_tc]++;
          m_drop[p_tc] = 1'b1;
        end else begin
          mq[p_tc].push_back(p_data);
          occ[p_tc]++;
        end
      end
      for (int t = 0; t < NUM_TC; t++) req[t] = (occ[t] != 0);
      if (m_state == NUM_TC || tx_ready) begin
        m_state = rr_pick(m_state, req & m_en & ~(pfc_xoff & m_pfc));
      end
      m_en    = new_en;
      m_pfc   = new_pfc;
      p_valid = in_valid;
      p_tc    = in_tc;
      p_data  = in_data;
    end
  end

  initial begin
    logic [31:0] r;
    int drops_before;
    mode     <= M_IDLE;
    cycles   <= 0;
    reset_n  <= 1'b0;
    in_valid <= 1'b0;
    in_tc    <= '0;
    in_data  <= '0;
    pfc_xoff <= '0;
    tx_ready <= 1'b1;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    mode    <= M_RAND;

    for (int seg = 0; seg < NUM_TC; seg++) begin
      repeat (RUN_CYCLES / 10) @(posedge clk);
      @(negedge clk);
      r = next_rand();
      apb_write(REG_TC_ENABLE, {24'h0, r[7:0] | 8'h01});
      apb_write(REG_PFC_ENABLE, {24'h0, r[15:8]});
      apb_read(REG_DROP_STATUS);
      apb_read(REG_TX_CNT_BASE + apb_addr_t'(4 * seg));
    end

    // Paused TC 3 filled past its depth
    apb_write(REG_TC_ENABLE, 32'hff);
    apb_write(REG_PFC_ENABLE, 32'hff);
    mode <= M_PAUSE;
    repeat (4) @(posedge clk);
    drops_before = drops[3];
    mode <= M_BURST;
    repeat (FIFO_DEPTH + 6) @(posedge clk);
    mode <= M_PAUSE;
    repeat (3) @(posedge clk);
    assert (drops[3] > drops_before)
      else begin
        $display("Burst into paused TC 3 caused no drop in the model");
        stop_failed();
      end
    apb_read(REG_DROP_STATUS);
    apb_write(REG_DROP_STATUS, 32'h08);
    apb_read(REG_DROP_STATUS);

    // Error responses
    apb_read(8'h0c);
    apb_read(8'h30);
    apb_write(REG_TX_CNT_BASE + 8'h04, 32'h1);
    apb_write(8'h0c, 32'h0);

    mode <= M_DRAIN;
    while (!drained()) @(posedge clk);
    for (int t = 0; t < NUM_TC; t++) begin
      apb_read(REG_TX_CNT_BASE + apb_addr_t'(4 * t));
    end
    repeat (2) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule : egr_tc_sched_tb

// ==== test/egr_tc_sched_properties.sv ====
/* Concurrent checks on the scheduler's grant, egress stream and APB handshake.
   Bound to every egr_tc_sched instance */

`timescale 1ns/1ps

module egr_tc_sched_properties #(
  parameter int DATA_WIDTH = 32
) (
  input logic                  clk,
  input logic                  reset_n,
  input egr_tc_pkg::tc_mask_t  tc_gnt,
  input logic                  tx_valid,
  input logic                  tx_ready,
  input egr_tc_pkg::tc_idx_t   tx_tc,
  input logic [DATA_WIDTH-1:0] tx_data,
  input logic                  psel,
  input logic                  penable,
  input logic                  pready
);

  a_gnt_onehot : assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0(tc_gnt))
    else $error("tc_gnt is not one-hot or zero: %h", tc_gnt);

  // Stalled word must not change
  a_tx_stable : assert property (@(posedge clk) disable iff (!reset_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_tc) && $stable(tx_data))
    else $error("egress word changed while stalled");

  a_pready : assert property (@(posedge clk) disable iff (!reset_n)
    psel && penable |-> pready)
    else $error("pready low in an access phase");

  a_reset_idle : assert property (@(posedge clk)
    !reset_n |=> !tx_valid)
    else $error("tx_valid high right after reset");

endmodule : egr_tc_sched_properties

bind egr_tc_sched egr_tc_sched_properties #(.DATA_WIDTH(DATA_WIDTH)) i_props (.*);

// ==== verilog/egr_tc_sched.sv ====
/* Egress traffic-class scheduler for one Ethernet port. Words enter eight
   per-TC FIFOs and leave on one valid/ready stream in round-robin order */

`timescale 1ns/1ps

module egr_tc_sched #(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  in_valid,
  input  egr_tc_pkg::tc_idx_t   in_tc,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  egr_tc_pkg::tc_mask_t  pfc_xoff,
  input  logic                  tx_ready,
  output logic                  tx_valid,
  output egr_tc_pkg::tc_idx_t   tx_tc,
  output logic [DATA_WIDTH-1:0] tx_data,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  egr_tc_pkg::apb_addr_t paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr
);

  import egr_tc_pkg::*;

  logic                  in_valid_q;
  tc_idx_t               in_tc_q;
  logic [DATA_WIDTH-1:0] in_data_q;
  tc_mask_t              push;
  tc_mask_t              pop;
  tc_mask_t              tc_req;
  tc_mask_t              tc_gnt;
  tc_mask_t              overflow;
  tc_mask_t              tc_enable;
  tc_mask_t              pfc_enable;
  logic [DATA_WIDTH-1:0] head_data [NUM_TC];

  // Ingress stage, a word reaches its FIFO the cycle after in_valid
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    in_tc_q   <= in_tc;
    in_data_q <= in_data;
  end

  assign push = in_valid_q ? (tc_mask_t'(1) << in_tc_q) : '0;
  assign pop  = tc_gnt & {NUM_TC{tx_ready}};  // Only on a transfer

  for (genvar i = 0; i < NUM_TC; i++) begin : g_fifo
    egr_tc_fifo #(
      .DATA_WIDTH (DATA_WIDTH),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
      .clk       (clk),
      .reset_n   (reset_n),
      .push      (push[i]),
      .push_data (in_data_q),
      .pop       (pop[i]),
      .head_data (head_data[i]),
      .req       (tc_req[i]),
      .overflow  (overflow[i])
    );
  end

  egr_tc_rr_sm i_rr_sm (
    .clk        (clk),
    .reset_n    (reset_n),
    .tc_req     (tc_req),
    .pfc_xoff   (pfc_xoff),
    .tc_enable  (tc_enable),
    .pfc_enable (pfc_enable),
    .tx_ready   (tx_ready),
    .tc_gnt     (tc_gnt)
  );

  egr_tc_apb_regs i_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .tc_gnt     (tc_gnt),
    .tx_ready   (tx_ready),
    .overflow   (overflow),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .tc_enable  (tc_enable),
    .pfc_enable (pfc_enable)
  );

  // Grant is one-hot or zero
  always_comb begin
    tx_tc = '0;
    for (int i = 0; i < NUM_TC; i++) begin
      if (tc_gnt[i]) begin
        tx_tc = tc_idx_t'(i);
      end
    end
  end

  assign tx_valid = |tc_gnt;
  assign tx_data  = head_data[tx_tc];

endmodule : egr_tc_sched

// ==== verilog/egr_tc_apb_regs.sv ====
/* APB register block of the scheduler. Holds the TC and PFC enable masks,
   the sticky per-TC drop status and the per-TC sent-word counters */

`timescale 1ns/1ps

module egr_tc_apb_regs (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  egr_tc_pkg::apb_addr_t paddr,
  input  logic [31:0]           pwdata,
  input  egr_tc_pkg::tc_mask_t  tc_gnt,
  input  logic                  tx_ready,
  input  egr_tc_pkg::tc_mask_t  overflow,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output egr_tc_pkg::tc_mask_t  tc_enable,
  output egr_tc_pkg::tc_mask_t  pfc_enable
);

  import egr_tc_pkg::*;

  tc_mask_t  drop_status;
  tc_mask_t  drop_clr;
  tx_cnt_t   tx_cnt [NUM_TC];
  apb_addr_t cnt_off;
  tc_idx_t   cnt_sel;
  logic      access;
  logic      hit_cnt;
  logic      mapped;
  logic      wr_en;

  assign access = psel & penable;

  // Counter window, word aligned
  assign cnt_off = paddr - REG_TX_CNT_BASE;
  assign cnt_sel = cnt_off[4:2];
  assign hit_cnt = (cnt_off < apb_addr_t'(4 * NUM_TC)) && (cnt_off[1:0] == 2'b00);

  assign mapped = (paddr == REG_TC_ENABLE) || (paddr == REG_PFC_ENABLE) ||
                  (paddr == REG_DROP_STATUS) || hit_cnt;

  assign pready  = 1'b1;  // No wait states
  assign pslverr = access & (~mapped | (pwrite & hit_cnt));  // Counters are read only
  assign wr_en   = access & pwrite & ~pslverr;

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (hit_cnt) begin
        prdata = 32'(tx_cnt[cnt_sel]);
      end else begin
        case (paddr)
          REG_TC_ENABLE:   prdata = 32'(tc_enable);
          REG_PFC_ENABLE:  prdata = 32'(pfc_enable);
          REG_DROP_STATUS: prdata = 32'(drop_status);
          default:         prdata = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tc_enable  <= '1;
      pfc_enable <= '1;
    end else if (wr_en) begin
      if (paddr == REG_TC_ENABLE) begin
        tc_enable <= pwdata[NUM_TC-1:0];
      end
      if (paddr == REG_PFC_ENABLE) begin
        pfc_enable <= pwdata[NUM_TC-1:0];
      end
    end
  end

  assign drop_clr = (wr_en && paddr == REG_DROP_STATUS) ? pwdata[NUM_TC-1:0] : '0;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      drop_status <= '0;
    end else begin
      drop_status <= (drop_status & ~drop_clr) | overflow;  // New drop beats a clear
    end
  end

  // One count per transferred word
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < NUM_TC; i++) begin
        tx_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_TC; i++) begin
        if (tc_gnt[i] && tx_ready) begin
          tx_cnt[i] <= tx_cnt[i] + tx_cnt_t'(1);
        end
      end
    end
  end

endmodule : egr_tc_apb_regs

// ==== verilog/egr_tc_rr_sm.sv ====
/* Round-robin traffic-class arbiter. Masks requests with the TC enables
   and paused classes, and holds its grant while the transmitter stalls */

`timescale 1ns/1ps

module egr_tc_rr_sm (
  input  logic                 clk,
  input  logic                 reset_n,
  input  egr_tc_pkg::tc_mask_t tc_req,
  input  egr_tc_pkg::tc_mask_t pfc_xoff,
  input  egr_tc_pkg::tc_mask_t tc_enable,
  input  egr_tc_pkg::tc_mask_t pfc_enable,
  input  logic                 tx_ready,
  output egr_tc_pkg::tc_mask_t tc_gnt
);

  import egr_tc_pkg::*;

  rr_state_t state;
  rr_state_t nx_state;
  tc_mask_t  qa_req;
  tc_mask_t  nx_gnt;
  tc_idx_t   start_idx;
  logic      advance;

  // Xoff only counts where pause honouring is on
  assign qa_req = tc_req & tc_enable & ~(pfc_xoff & pfc_enable);

  // From IDLE the search wraps round to TC 0 first
  assign start_idx = (state == IDLE) ? tc_idx_t'(NUM_TC - 1) : state[2:0];

  always_comb begin : rr_search
    tc_idx_t cand;
    logic    found;

    found    = 1'b0;
    nx_state = IDLE;
    // Offset NUM_TC lands back on the current TC, lowest priority
    for (int i = 1; i <= NUM_TC; i++) begin
      cand = start_idx + tc_idx_t'(i);
      if (!found && qa_req[cand]) begin
        nx_state = rr_state_t'({1'b0, cand});
        found    = 1'b1;
      end
    end
  end : rr_search

  assign nx_gnt = (nx_state == IDLE) ? '0 : tc_mask_t'(1) << nx_state[2:0];

  // A pending grant waits for the transmitter
  assign advance = ~|tc_gnt | tx_ready;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state  <= IDLE;
      tc_gnt <= '0;
    end else if (advance) begin
      state  <= nx_state;
      tc_gnt <= nx_gnt;  // One-hot copy of the next state
    end
  end

endmodule : egr_tc_rr_sm

// ==== verilog/egr_tc_fifo.sv ====
/* Word FIFO for one traffic class. Drives a look-ahead request for the
   arbiter and pulses overflow when a push finds the buffer full */

`timescale 1ns/1ps

module egr_tc_fifo #(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  push,
  input  logic [DATA_WIDTH-1:0] push_data,
  input  logic                  pop,
  output logic [DATA_WIDTH-1:0] head_data,
  output logic                  req,
  output logic                  overflow
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [CW-1:0]         count;
  logic [CW-1:0]         count_nx;
  logic                  full;
  logic                  wr_ok;
  logic                  rd_ok;

  assign full     = (count == CW'(FIFO_DEPTH));
  assign wr_ok    = push && !full;
  assign rd_ok    = pop && (count != '0);
  assign overflow = push && full;  // Word is discarded

  assign count_nx = count + CW'(wr_ok) - CW'(rd_ok);

  // Occupancy after this cycle, so a grant issued next cycle finds data
  assign req = (count_nx != '0);

  assign head_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      count <= count_nx;
      if (wr_ok) begin
        wr_ptr <= wr_ptr + AW'(1);  // Depth is a power of two, pointers wrap
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule : egr_tc_fifo

// ==== verilog/egr_tc_pkg.sv ====
/* Shared widths, APB register map and arbiter state encoding for the
   egress traffic-class scheduler. Imported by the RTL and the testbench */

package egr_tc_pkg;

  // The arbiter is written for exactly eight classes
  localparam int NUM_TC = 8;

  typedef logic [NUM_TC-1:0] tc_mask_t;  // One bit per TC
  typedef logic [2:0]        tc_idx_t;
  typedef logic [15:0]       tx_cnt_t;   // Wraps
  typedef logic [7:0]        apb_addr_t;

  // APB byte offsets
  localparam apb_addr_t REG_TC_ENABLE   = 8'h00;
  localparam apb_addr_t REG_PFC_ENABLE  = 8'h04;
  localparam apb_addr_t REG_DROP_STATUS = 8'h08;  // W1C
  localparam apb_addr_t REG_TX_CNT_BASE = 8'h10;  // TC i at base + 4*i, read only

  // GRANTn encodes as n so the low bits give the TC index
  typedef enum logic [3:0] {
    GRANT0 = 4'h0,
    GRANT1 = 4'h1,
    GRANT2 = 4'h2,
    GRANT3 = 4'h3,
    GRANT4 = 4'h4,
    GRANT5 = 4'h5,
    GRANT6 = 4'h6,
    GRANT7 = 4'h7,
    IDLE   = 4'h8
  } rr_state_t;

endpackage : egr_tc_pkg
